// File: gcode_linear.f
+incdir+verilog
verilog/gcode_pkg.sv
verilog/char_fifo.sv
verilog/number_scanner.sv
verilog/linear_subparser.sv
verilog/position_keeper.sv
verilog/gcode_linear_top.sv
tests/gcode_linear_assertions.sv
tests/gcode_linear_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the G01 parser testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module gcode_linear_tb \
	-f gcode_linear.f \
	-o gcode_linear_sim

./obj_dir/gcode_linear_sim

// File: tests/gcode_linear_tb.sv
`include "gcode_cfg.svh"

module gcode_linear_tb import gcode_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DONE_LIMIT = 400;
	localparam int RDY_LIMIT = 50;
	localparam int WRITE_LIMIT = `FIFO_DEPTH * 8; // Parser drains a full queue well within this

	logic sub_intf;
	logic reset;
	logic wr_valid;
	logic [`BYTE_BITS-1:0] wr_data;
	logic full;
	op_cmd_e cmd;
	logic trigger;
	logic rdy;
	logic done;
	logic success;
	logic newline;
	op_cmd_e op_cmd;
	coord_t arg_x;
	coord_t arg_y;
	coord_t arg_f;
	logic [FLAG_BITS-1:0] flags;
	coord_t cur_x;
	coord_t cur_y;

	coord_t model_x; // Expected position
	coord_t model_y;
	logic [31:0] lfsr_state = 32'h45ce;

	gcode_linear_top uut (.*);

	initial begin
		sub_intf = 1'b0;
		forever #20 sub_intf = ~sub_intf;
	end

	////////////////////
	// Checking

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic compare_coord(input string what, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			$display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic compare_cmd(input op_cmd_e got, input op_cmd_e exp);
		if (got !== exp) begin
			$display("error %0t: op_cmd is %s, expected %s", $time, got.name(), exp.name());
			stop_run();
		end
	endtask

	task automatic compare_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_result(input logic has_x, input logic has_y, input logic has_f,
			input coord_t ex, input coord_t ey, input coord_t ef);
		compare_cmd(op_cmd, OP_CMD_G01);
		compare_bit("success", success, 1'b1);
		compare_bit("newline", newline, 1'b1);
		compare_bit("flag X", flags[FLAG_X], has_x);
		compare_bit("flag Y", flags[FLAG_Y], has_y);
		compare_bit("flag F", flags[FLAG_F], has_f);
		compare_coord("arg_x", arg_x, ex);
		compare_coord("arg_y", arg_y, ey);
		compare_coord("arg_f", arg_f, ef);
		if (has_x) model_x = ex; // Absent axes keep their place
		if (has_y) model_y = ey;
	endtask

	task automatic check_failed_line();
		compare_bit("success", success, 1'b0);
		compare_bit("newline", newline, 1'b1);
	endtask

	task automatic check_position();
		@(negedge sub_intf); // Keeper loads one cycle after done
		compare_coord("cur_x", cur_x, model_x);
		compare_coord("cur_y", cur_y, model_y);
	endtask

	////////////////////
	// Driving

	task automatic write_line(input string text);
		int cycles;
		for (int i = 0; i < text.len(); i++) begin
			@(posedge sub_intf);
			wr_valid <= 1'b1;
			wr_data <= text[i];
			cycles = 0;
			@(negedge sub_intf);
			while (full) begin
				if (cycles == WRITE_LIMIT) begin
					$display("timeout: the character FIFO stayed full");
					stop_run();
				end
				cycles++;
				@(negedge sub_intf);
			end
		end
		@(posedge sub_intf); // Last byte is taken on this edge
		wr_valid <= 1'b0;
	endtask

	task automatic start_line();
		int cycles;
		cycles = 0;
		@(negedge sub_intf);
		while (!rdy) begin
			if (cycles == RDY_LIMIT) begin
				$display("timeout: the parser never became ready");
				stop_run();
			end
			cycles++;
			@(negedge sub_intf);
		end
		@(posedge sub_intf);
		cmd <= OP_CMD_G01;
		trigger <= 1'b1;
		@(posedge sub_intf);
		trigger <= 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(negedge sub_intf);
		while (!done) begin
			if (cycles == DONE_LIMIT) begin
				$display("timeout: the parser never signalled done");
				stop_run();
			end
			cycles++;
			@(negedge sub_intf);
		end
	endtask

	task automatic run_line(input string text);
		write_line(text);
		start_line();
		wait_done();
	endtask

	////////////////////
	// Random values

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
	endfunction

	task automatic random_bits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	function automatic string coord_text(input coord_t v);
		int value;
		int mag;
		string sign;
		value = v;
		mag = (value < 0) ? -value : value;
		sign = "";
		if (value < 0) sign = "-";
		return $sformatf("%s%0d.%0d", sign, mag / 10, mag % 10);
	endfunction

	////////////////////
	// Tests

	task automatic test_full_move();
		run_line(" X 1.1 Y 1.1 F 0\n");
		check_result(1'b1, 1'b1, 1'b1, 20'sd11, 20'sd11, 20'sd0);
		check_position();
	endtask

	task automatic test_empty_arg();
		run_line(" X\n");
		check_failed_line();
		check_position();
	endtask

	task automatic test_single_axis();
		run_line(" X 3.4\n");
		check_result(1'b1, 1'b0, 1'b0, 20'sd34, 20'sd0, 20'sd0);
		check_position();
	endtask

	task automatic test_signs_and_errors();
		run_line(" X-2 Y-0.5\n");
		check_result(1'b1, 1'b1, 1'b0, -20'sd20, -20'sd5, 20'sd0);
		check_position();
		run_line(" X 1 X 2\n"); // Repeated letter
		check_failed_line();
		check_position();
		run_line(" Y 1.25\n");
		check_failed_line();
		check_position();
	endtask

	task automatic test_starvation();
		write_line(" X 5 Y");
		start_line();
		for (int i = 0; i < 20; i++) begin
			@(negedge sub_intf);
			if (done) begin
				$display("done came before the newline was written");
				stop_run();
			end
		end
		write_line("-1.5\n");
		wait_done();
		check_result(1'b1, 1'b1, 1'b0, 20'sd50, -20'sd15, 20'sd0);
		check_position();
	endtask

	// One line padded with spaces to exactly the queue depth
	task automatic test_full_queue();
		string text;
		text = " X 7.2";
		while (text.len() < `FIFO_DEPTH - 1) text = {text, " "};
		text = {text, "\n"};
		write_line(text);
		@(negedge sub_intf);
		compare_bit("full", full, 1'b1);
		start_line();
		wait_done();
		compare_bit("full", full, 1'b0);
		check_result(1'b1, 1'b0, 1'b0, 20'sd72, 20'sd0, 20'sd0);
		check_position();
	endtask

	task automatic test_random_moves();
		logic [31:0] bits;
		coord_t rx;
		coord_t ry;
		logic has_x;
		logic has_y;
		string text;
		for (int n = 0; n < 10; n++) begin
			random_bits(`COORD_BITS, bits);
			rx = bits[`COORD_BITS-1:0];
			random_bits(`COORD_BITS, bits);
			ry = bits[`COORD_BITS-1:0];
			random_bits(2, bits);
			has_x = bits[0] || !bits[1]; // At least one axis per line
			has_y = bits[1];
			text = "";
			if (has_x) text = {text, " X ", coord_text(rx)};
			if (has_y) text = {text, " Y", coord_text(ry)};
			run_line({text, "\n"});
			check_result(has_x, has_y, 1'b0, has_x ? rx : '0, has_y ? ry : '0, '0);
			check_position();
		end
	endtask

	initial begin
		reset = 1'b1;
		wr_valid = 1'b0;
		wr_data = '0;
		cmd = OP_CMD_NONE;
		trigger = 1'b0;
		model_x = '0;
		model_y = '0;
		repeat (4) @(posedge sub_intf);
		reset <= 1'b0;
		@(negedge sub_intf);
		compare_bit("rdy", rdy, 1'b1);
		compare_bit("full", full, 1'b0);
		compare_cmd(op_cmd, OP_CMD_NONE);
		compare_coord("cur_x", cur_x, '0);
		compare_coord("cur_y", cur_y, '0);

		test_full_move();
		test_empty_arg();
		test_single_axis();
		test_signs_and_errors();
		test_starvation();
		test_full_queue();
		test_random_moves();

		$display("Test OK");
		$finish;
	end

endmodule : gcode_linear_tb

// File: tests/gcode_linear_assertions.sv
module gcode_linear_assertions import gcode_pkg::*; (
	input logic sub_intf,
	input logic reset,
	input logic trigger,
	input logic rdy,
	input logic done,
	input logic success,
	input logic is_empty,
	input logic rd_trigger,
	input logic upd_valid,
	input logic [FLAG_BITS-1:0] flags
);

	timeunit 1ns;
	timeprecision 100ps;

	logic in_flight; // Between an accepted trigger and its done

	always_ff @(posedge sub_intf) begin
		if (reset) begin
			in_flight <= 1'b0;
		end else if (rdy && trigger) begin
			in_flight <= 1'b1;
		end else if (done) begin
			in_flight <= 1'b0;
		end
	end

	////////////////////
	// Handshake rules

	done_pulse: assert property (@(posedge sub_intf) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	pop_not_empty: assert property (@(posedge sub_intf) disable iff (reset)
		rd_trigger |-> !is_empty && in_flight)
		else $error("rd_trigger while the FIFO is empty or no line is in flight");

	update_ok: assert property (@(posedge sub_intf) disable iff (reset)
		upd_valid |-> success && (flags != '0))
		else $error("upd_valid without success or without any argument word");

	busy_not_ready: assert property (@(posedge sub_intf) disable iff (reset) in_flight |-> !rdy)
		else $error("rdy high while a line is in flight");

endmodule : gcode_linear_assertions

bind linear_subparser gcode_linear_assertions sva_chk (
	.sub_intf(sub_intf),
	.reset(reset),
	.trigger(trigger),
	.rdy(rdy),
	.done(done),
	.success(success),
	.is_empty(is_empty),
	.rd_trigger(rd_trigger),
	.upd_valid(upd_valid),
	.flags(flags)
);

// File: verilog/gcode_linear_top.sv
`include "gcode_cfg.svh"

module gcode_linear_top import gcode_pkg::*; (
	input logic sub_intf,
	input logic reset,
	input logic wr_valid,
	input logic [`BYTE_BITS-1:0] wr_data,
	output logic full,
	input op_cmd_e cmd,
	input logic trigger,
	output logic rdy,
	output logic done,
	output logic success,
	output logic newline,
	output op_cmd_e op_cmd,
	output coord_t arg_x,
	output coord_t arg_y,
	output coord_t arg_f,
	output logic [FLAG_BITS-1:0] flags,
	output coord_t cur_x,
	output coord_t cur_y
);

	logic [`BYTE_BITS-1:0] rd_data;
	logic is_empty;
	logic rd_trigger;
	logic upd_valid;

	char_fifo fifo_buf (
		.sub_intf(sub_intf),
		.reset(reset),
		.wr_valid(wr_valid),
		.wr_data(wr_data),
		.full(full),
		.rd_trigger(rd_trigger),
		.rd_data(rd_data),
		.is_empty(is_empty)
	);

	linear_subparser parser (
		.sub_intf(sub_intf),
		.reset(reset),
		.cmd(cmd),
		.trigger(trigger),
		.rdy(rdy),
		.done(done),
		.success(success),
		.newline(newline),
		.rd_data(rd_data),
		.is_empty(is_empty),
		.rd_trigger(rd_trigger),
		.op_cmd(op_cmd),
		.arg_x(arg_x),
		.arg_y(arg_y),
		.arg_f(arg_f),
		.flags(flags),
		.upd_valid(upd_valid)
	);

	position_keeper pos_keeper (
		.sub_intf(sub_intf),
		.reset(reset),
		.upd_valid(upd_valid),
		.op_cmd(op_cmd),
		.arg_x(arg_x),
		.arg_y(arg_y),
		.flags(flags),
		.cur_x(cur_x),
		.cur_y(cur_y)
	);

endmodule : gcode_linear_top

// File: verilog/position_keeper.sv
`include "gcode_cfg.svh"

module position_keeper import gcode_pkg::*; (
	input logic sub_intf,
	input logic reset,
	input logic upd_valid,
	input op_cmd_e op_cmd,
	input coord_t arg_x,
	input coord_t arg_y,
	input logic [FLAG_BITS-1:0] flags,
	output coord_t cur_x,
	output coord_t cur_y
);

	logic apply_move;

	assign apply_move = upd_valid && op_cmd == OP_CMD_G01;

	// Absolute coordinates, an axis missing from the line stays put
	always_ff @(posedge sub_intf) begin
		if (reset) begin
			cur_x <= '0;
			cur_y <= '0;
		end else if (apply_move) begin
			if (flags[FLAG_X]) cur_x <= arg_x;
			if (flags[FLAG_Y]) cur_y <= arg_y;
		end
	end

endmodule : position_keeper

// File: verilog/linear_subparser.sv
`include "gcode_cfg.svh"

module linear_subparser import gcode_pkg::*; (
	input logic sub_intf,
	input logic reset,
	input op_cmd_e cmd,
	input logic trigger,
	output logic rdy,
	output logic done,
	output logic success,
	output logic newline,
	input logic [`BYTE_BITS-1:0] rd_data,
	input logic is_empty,
	output logic rd_trigger,
	output op_cmd_e op_cmd,
	output coord_t arg_x,
	output coord_t arg_y,
	output coord_t arg_f,
	output logic [FLAG_BITS-1:0] flags,
	output logic upd_valid
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_WORD = 3'd1;
	localparam logic [2:0] ST_NUM = 3'd2;
	localparam logic [2:0] ST_DISCARD = 3'd3; // Line already failed, wait for its end
	localparam logic [2:0] ST_FINISH = 3'd4;

	logic [2:0] state;
	logic [FLAG_BITS-1:0] target; // Argument the running number goes to
	logic [FLAG_BITS-1:0] letter_mask;
	logic char_valid;
	logic word_step;
	logic is_space;
	logic is_nl;
	logic word_bad;
	logic num_fail;
	logic scan_start;
	logic scan_valid;
	logic num_busy;
	logic num_ended;
	logic num_bad;
	coord_t num_value;

	number_scanner scanner (
		.sub_intf(sub_intf),
		.reset(reset),
		.start(scan_start),
		.char_valid(scan_valid),
		.char_in(rd_data),
		.value(num_value),
		.busy(num_busy),
		.ended(num_ended),
		.bad(num_bad)
	);

	////////////////////
	// Character decode

	assign is_space = rd_data == " ";
	assign is_nl = rd_data == "\n";

	always_comb begin
		letter_mask = '0;
		letter_mask[FLAG_X] = rd_data == "X";
		letter_mask[FLAG_Y] = rd_data == "Y";
		letter_mask[FLAG_F] = rd_data == "F";
	end

	assign char_valid = !is_empty && (state == ST_WORD || state == ST_NUM || state == ST_DISCARD);
	assign rd_trigger = char_valid; // Every byte is used in the cycle it shows up
	assign scan_valid = char_valid && num_busy;

	// The character that ends a number is also a word character
	assign word_step = char_valid && (state == ST_WORD || num_ended);
	assign num_fail = num_ended && num_bad;
	assign word_bad = !is_space && !is_nl && (letter_mask == '0 || (letter_mask & flags) != '0);
	assign scan_start = word_step && !num_fail && !word_bad && !is_space && !is_nl;

	assign rdy = state == ST_IDLE;
	assign done = state == ST_FINISH;
	assign upd_valid = done && success;

	////////////////////
	// Line state

	always_ff @(posedge sub_intf) begin
		if (reset) begin
			state <= ST_IDLE;
			target <= '0;
			op_cmd <= OP_CMD_NONE;
			arg_x <= '0;
			arg_y <= '0;
			arg_f <= '0;
			flags <= '0;
			success <= 1'b0;
			newline <= 1'b0;
		end else if (state == ST_IDLE) begin
			if (trigger) begin
				op_cmd <= cmd;
				arg_x <= '0;
				arg_y <= '0;
				arg_f <= '0;
				flags <= '0;
				success <= cmd == OP_CMD_G01;
				newline <= 1'b0;
				state <= (cmd == OP_CMD_G01) ? ST_WORD : ST_DISCARD; // Only linear moves here
			end
		end else if (state == ST_FINISH) begin
			state <= ST_IDLE;
		end else if (char_valid) begin
			if (num_ended && !num_bad) begin
				if (target[FLAG_X]) arg_x <= num_value;
				if (target[FLAG_Y]) arg_y <= num_value;
				if (target[FLAG_F]) arg_f <= num_value;
			end

			if (is_nl) begin
				newline <= 1'b1;
				success <= success && !num_fail && flags != '0; // A bare G01 is no move
				state <= ST_FINISH;
			end else if (num_fail || (word_step && word_bad)) begin
				success <= 1'b0;
				state <= ST_DISCARD;
			end else if (scan_start) begin
				flags <= flags | letter_mask;
				target <= letter_mask;
				state <= ST_NUM;
			end else if (word_step) begin
				state <= ST_WORD;
			end
		end
	end

endmodule : linear_subparser

// File: verilog/number_scanner.sv
`include "gcode_cfg.svh"

module number_scanner import gcode_pkg::*; (
	input logic sub_intf,
	input logic reset,
	input logic start,
	input logic char_valid,
	input logic [`BYTE_BITS-1:0] char_in,
	output coord_t value,
	output logic busy,
	output logic ended,
	output logic bad
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_LEAD = 3'd1; // Spaces before the number
	localparam logic [2:0] S_SIGN = 3'd2;
	localparam logic [2:0] S_INT = 3'd3;
	localparam logic [2:0] S_POINT = 3'd4;
	localparam logic [2:0] S_FRAC = 3'd5;

	logic [2:0] state;
	logic [`COORD_BITS-1:0] acc; // Magnitude in tenths
	logic neg;
	logic saw_digit;
	logic extra; // More than one fractional digit
	logic is_digit;
	logic is_point;
	logic is_minus;
	logic is_space;
	logic terminate;
	logic [`COORD_BITS-1:0] digit;

	function automatic logic [`COORD_BITS-1:0] times_ten(input logic [`COORD_BITS-1:0] v);
		return (v << 3) + (v << 1);
	endfunction

	assign is_digit = (char_in >= "0") && (char_in <= "9");
	assign is_point = char_in == ".";
	assign is_minus = char_in == "-";
	assign is_space = char_in == " ";
	assign digit = {{(`COORD_BITS - 4){1'b0}}, char_in[3:0]}; // ASCII digits carry their value low

	always_comb begin
		case (state)
			S_LEAD: terminate = !(is_space || is_minus || is_digit || is_point);
			S_SIGN, S_INT: terminate = !(is_digit || is_point);
			S_POINT, S_FRAC: terminate = !is_digit;
			default: terminate = 1'b0;
		endcase
	end

	assign busy = state != S_IDLE;
	assign ended = busy && char_valid && terminate;
	assign bad = ended && (!saw_digit || extra);
	assign value = neg ? -acc : acc;

	always_ff @(posedge sub_intf) begin
		if (reset) begin
			state <= S_IDLE;
			acc <= '0;
			neg <= 1'b0;
			saw_digit <= 1'b0;
			extra <= 1'b0;
		end else if (start) begin
			state <= S_LEAD;
			acc <= '0;
			neg <= 1'b0;
			saw_digit <= 1'b0;
			extra <= 1'b0;
		end else if (busy && char_valid) begin
			if (terminate) begin
				state <= S_IDLE; // The caller decodes this character itself
			end else if (is_point) begin
				state <= S_POINT;
			end else if (is_minus) begin
				neg <= 1'b1;
				state <= S_SIGN;
			end else if (is_digit) begin
				saw_digit <= 1'b1;
				case (state)
					S_POINT: begin
						acc <= acc + digit;
						state <= S_FRAC;
					end
					S_FRAC: extra <= 1'b1;
					default: begin
						acc <= times_ten(acc) + times_ten(digit);
						state <= S_INT;
					end
				endcase
			end
		end
	end

endmodule : number_scanner

// File: verilog/char_fifo.sv
`include "gcode_cfg.svh"

module char_fifo (
	input logic sub_intf,
	input logic reset,
	input logic wr_valid,
	input logic [`BYTE_BITS-1:0] wr_data,
	output logic full,
	input logic rd_trigger,
	output logic [`BYTE_BITS-1:0] rd_data,
	output logic is_empty
);

	localparam int PTR_BITS = $clog2(`FIFO_DEPTH);

	logic [`BYTE_BITS-1:0] mem [`FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] count;
	logic do_wr;
	logic do_rd;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_wr = wr_valid && !full; // Host is held off while full
	assign do_rd = rd_trigger && !is_empty;

	assign full = count == (PTR_BITS + 1)'(`FIFO_DEPTH);
	assign is_empty = count == '0;
	assign rd_data = mem[rd_ptr]; // Head byte is always on show

	always_ff @(posedge sub_intf) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge sub_intf) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= next_ptr(wr_ptr);
			if (do_rd) rd_ptr <= next_ptr(rd_ptr);

			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither leaves the fill level
			endcase
		end
	end

endmodule : char_fifo

// File: verilog/gcode_pkg.sv
`include "gcode_cfg.svh"

package gcode_pkg;

	////////////////////
	// Commands

	// Codes handed over by the main parser once it has read the G token
	typedef enum logic [3:0] {
		OP_CMD_NONE = 4'd0,
		OP_CMD_G01 = 4'd1
	} op_cmd_e;

	////////////////////
	// Arguments

	typedef logic signed [`COORD_BITS-1:0] coord_t; // Tenths of a unit

	// One bit per argument word, set when the word was on the line
	localparam int FLAG_BITS = 3;
	localparam int FLAG_X = 0;
	localparam int FLAG_Y = 1;
	localparam int FLAG_F = 2;

endpackage : gcode_pkg

// File: verilog/gcode_cfg.svh
`ifndef GCODE_CFG_SVH
`define GCODE_CFG_SVH

////////////////////
// Character path

`define BYTE_BITS 8

// Slots in the host character queue
`define FIFO_DEPTH 64

////////////////////
// Coordinates

// Signed, in tenths of a unit
`define COORD_BITS 20

`endif
